// ==== hw/jedro_1_pkg.sv ====
// Jedro-1 execute slice package

package jedro_1_pkg;

  ////////////////////////////////////////////////////////////
  // Widths fixed by the RV32I ISA
  ////////////////////////////////////////////////////////////

  // Data path width
  localparam int XLEN           = 32;
  // Register index width
  localparam int REG_ADDR_WIDTH = 5;
  // Integer registers x0-x31
  localparam int NUM_REGS       = 2 ** REG_ADDR_WIDTH;

  ////////////////////////////////////////////////////////////
  // Instruction encodings
  ////////////////////////////////////////////////////////////

  // Supported major opcodes
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111
  } opcode_e;

  // funct3 values shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7 values, ALT selects SUB and SRA/SRAI
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // ALU operation select
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_LUI
  } alu_op_e;

  ////////////////////////////////////////////////////////////
  // Pipeline bundles
  ////////////////////////////////////////////////////////////

  // Decoded control word, decoder to regfile and ALU
  typedef struct packed {
    logic                      valid;
    alu_op_e                   alu_op;
    logic [REG_ADDR_WIDTH-1:0] rs1;
    logic [REG_ADDR_WIDTH-1:0] rs2;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic                      use_imm;
    // I immediate, shift amount or shifted U immediate
    logic [XLEN-1:0]           imm;
  } dec_ctrl_t;

  // Writeback bundle
  typedef struct packed {
    logic                      valid;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic [XLEN-1:0]           data;
  } wb_t;

endpackage

// ==== hw/jedro_1_decoder.sv ====
// Jedro-1 instruction decoder

module jedro_1_decoder import jedro_1_pkg::*; (
  input  logic        clk_i,
  input  logic        rstn_i,

  // Instruction stream, no back-pressure
  input  logic        instr_valid_i,
  input  logic [31:0] instr_i,

  // Registered control word
  output dec_ctrl_t   ctrl_o,
  // One-cycle pulse for an unsupported encoding
  output logic        illegal_o
);

  // Instruction fields
  opcode_e                   opcode;
  logic [2:0]                funct3;
  logic [6:0]                funct7;
  logic [REG_ADDR_WIDTH-1:0] rd;
  logic [REG_ADDR_WIDTH-1:0] rs1;
  logic [REG_ADDR_WIDTH-1:0] rs2;

  // Immediate variants
  logic [XLEN-1:0]           i_imm;
  logic [XLEN-1:0]           u_imm;
  logic [XLEN-1:0]           shamt_imm;

  // Next-state control
  dec_ctrl_t                 ctrl_d;
  logic                      legal;
  logic                      shift_alt;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign rd     = instr_i[11:7];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];

  // Sign-extended 12-bit immediate
  assign i_imm     = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
  // Upper immediate lands in bits 31:12
  assign u_imm     = {instr_i[31:12], 12'b0};
  // Shift amount sits in the rs2 field
  assign shamt_imm = {{(XLEN-5){1'b0}}, instr_i[24:20]};

  // Only SRAI uses funct7 on the immediate side
  assign shift_alt = (funct3 == F3_SRL_SRA) && funct7[5];

  // funct3 to ALU operation, alt picks SUB or SRA
  function automatic alu_op_e f3_to_op(input logic [2:0] f3, input logic alt);
    case (f3)
      F3_ADD_SUB: f3_to_op = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:     f3_to_op = ALU_SLL;
      F3_SLT:     f3_to_op = ALU_SLT;
      F3_SLTU:    f3_to_op = ALU_SLTU;
      F3_XOR:     f3_to_op = ALU_XOR;
      F3_SRL_SRA: f3_to_op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:      f3_to_op = ALU_OR;
      default:    f3_to_op = ALU_AND;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    ctrl_d     = '0;
    ctrl_d.rs1 = rs1;
    ctrl_d.rs2 = rs2;
    ctrl_d.rd  = rd;
    legal      = 1'b0;
    case (opcode)
      OPC_OP: begin
        // ALT funct7 only for SUB and SRA
        legal = (funct7 == F7_BASE) ||
                ((funct7 == F7_ALT) && ((funct3 == F3_ADD_SUB) || (funct3 == F3_SRL_SRA)));
        ctrl_d.alu_op = f3_to_op(funct3, funct7[5]);
      end
      OPC_OP_IMM: begin
        ctrl_d.use_imm = 1'b1;
        ctrl_d.alu_op  = f3_to_op(funct3, shift_alt);
        case (funct3)
          F3_SLL: begin
            legal      = (funct7 == F7_BASE);
            ctrl_d.imm = shamt_imm;
          end
          F3_SRL_SRA: begin
            legal      = (funct7 == F7_BASE) || (funct7 == F7_ALT);
            ctrl_d.imm = shamt_imm;
          end
          default: begin
            legal      = 1'b1;
            ctrl_d.imm = i_imm;
          end
        endcase
      end
      OPC_LUI: begin
        // No register operands
        legal          = 1'b1;
        ctrl_d.alu_op  = ALU_LUI;
        ctrl_d.use_imm = 1'b1;
        ctrl_d.imm     = u_imm;
        ctrl_d.rs1     = '0;
        ctrl_d.rs2     = '0;
      end
      default: legal = 1'b0;
    endcase
    ctrl_d.valid = instr_valid_i && legal;
  end

  ////////////////////////////////////////////////////////////
  // Stage 1 register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      ctrl_o    <= '0;
      illegal_o <= 1'b0;
    end else begin
      ctrl_o    <= ctrl_d;
      illegal_o <= instr_valid_i && !legal;
    end
  end

endmodule

// ==== hw/jedro_1_regfile.sv ====
// Jedro-1 integer register file

module jedro_1_regfile import jedro_1_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rstn_i,

  // Read port A
  input  logic [REG_ADDR_WIDTH-1:0] rpa_addr_i,
  output logic [XLEN-1:0]           rpa_data_o,

  // Read port B
  input  logic [REG_ADDR_WIDTH-1:0] rpb_addr_i,
  output logic [XLEN-1:0]           rpb_data_o,

  // Write port C
  input  logic [REG_ADDR_WIDTH-1:0] wpc_addr_i,
  input  logic [XLEN-1:0]           wpc_data_i,
  input  logic                      wpc_we_i,

  // Destination index buffer
  input  logic [REG_ADDR_WIDTH-1:0] reg_alu_dest_i,
  output logic [REG_ADDR_WIDTH-1:0] reg_alu_dest_o,

  // Writeback enable buffer
  input  logic                      reg_alu_wb_i,
  output logic                      reg_alu_wb_o
);

  // x0-x31
  logic [XLEN-1:0] regs [NUM_REGS];

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  // Asynchronous reads
  assign rpa_data_o = regs[rpa_addr_i];
  assign rpb_data_o = regs[rpb_addr_i];

  // x0 is never written, so it stays zero after reset
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wpc_we_i && (wpc_addr_i != '0)) begin
      regs[wpc_addr_i] <= wpc_data_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Destination and enable buffer stage
  ////////////////////////////////////////////////////////////

  // Runs in step with the ALU result register
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      reg_alu_dest_o <= '0;
      reg_alu_wb_o   <= 1'b0;
    end else begin
      reg_alu_dest_o <= reg_alu_dest_i;
      reg_alu_wb_o   <= reg_alu_wb_i;
    end
  end

endmodule

// ==== hw/jedro_1_alu.sv ====
// Jedro-1 ALU stage

module jedro_1_alu import jedro_1_pkg::*; (
  input  logic            clk_i,
  input  logic            rstn_i,

  // Decoded control word
  input  dec_ctrl_t       ctrl_i,

  // Register file read data
  input  logic [XLEN-1:0] rs1_data_i,
  input  logic [XLEN-1:0] rs2_data_i,

  // Writeback in flight, not yet in the register file
  input  wb_t             fwd_i,

  // Registered result
  output logic [XLEN-1:0] result_o
);

  logic            fwd_a;
  logic            fwd_b;
  logic [XLEN-1:0] reg_a;
  logic [XLEN-1:0] reg_b;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [4:0]      shamt;
  logic            lt_signed;
  logic            lt_unsigned;
  logic [XLEN-1:0] result_d;

  ////////////////////////////////////////////////////////////
  // Operand selection
  ////////////////////////////////////////////////////////////

  // Back-to-back dependence on a nonzero rd
  assign fwd_a = fwd_i.valid && (fwd_i.rd != '0) && (fwd_i.rd == ctrl_i.rs1);
  assign fwd_b = fwd_i.valid && (fwd_i.rd != '0) && (fwd_i.rd == ctrl_i.rs2);

  assign reg_a = fwd_a ? fwd_i.data : rs1_data_i;
  assign reg_b = fwd_b ? fwd_i.data : rs2_data_i;

  assign op_a = reg_a;
  // Immediate replaces rs2 for OP-IMM and LUI
  assign op_b = ctrl_i.use_imm ? ctrl_i.imm : reg_b;

  // Shifts use the low five bits only
  assign shamt = op_b[4:0];

  // Compare results
  assign lt_signed   = $signed(op_a) < $signed(op_b);
  assign lt_unsigned = op_a < op_b;

  ////////////////////////////////////////////////////////////
  // Operations
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (ctrl_i.alu_op)
      ALU_ADD:  result_d = op_a + op_b;
      ALU_SUB:  result_d = op_a - op_b;
      ALU_SLL:  result_d = op_a << shamt;
      ALU_SLT:  result_d = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: result_d = {{(XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR:  result_d = op_a ^ op_b;
      ALU_SRL:  result_d = op_a >> shamt;
      // Arithmetic shift keeps the sign
      ALU_SRA:  result_d = $unsigned($signed(op_a) >>> shamt);
      ALU_OR:   result_d = op_a | op_b;
      ALU_AND:  result_d = op_a & op_b;
      // U immediate passes straight through
      ALU_LUI:  result_d = op_b;
      default:  result_d = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Result register
  ////////////////////////////////////////////////////////////

  // Loads only on a valid instruction
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      result_o <= '0;
    end else if (ctrl_i.valid) begin
      result_o <= result_d;
    end
  end

endmodule

// ==== hw/jedro_1_exec_top.sv ====
// Jedro-1 execute slice top

module jedro_1_exec_top import jedro_1_pkg::*; (
  input  logic        clk_i,
  input  logic        rstn_i,

  // Instruction stream
  input  logic        instr_valid_i,
  input  logic [31:0] instr_i,

  // Writeback and illegal pulse
  output wb_t         wb_o,
  output logic        illegal_o
);

  // Stage 2 control word
  dec_ctrl_t                 ctrl;

  // Operand read data
  logic [XLEN-1:0]           rs1_data;
  logic [XLEN-1:0]           rs2_data;

  // Stage 3 pieces
  logic [XLEN-1:0]           alu_result;
  logic [REG_ADDR_WIDTH-1:0] wb_dest;
  logic                      wb_en;
  wb_t                       wb;

  ////////////////////////////////////////////////////////////
  // Stage 1
  ////////////////////////////////////////////////////////////

  jedro_1_decoder u_decoder (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .ctrl_o        (ctrl),
    .illegal_o     (illegal_o)
  );

  ////////////////////////////////////////////////////////////
  // Stage 2 and writeback
  ////////////////////////////////////////////////////////////

  jedro_1_regfile u_regfile (
    .clk_i          (clk_i),
    .rstn_i         (rstn_i),
    .rpa_addr_i     (ctrl.rs1),
    .rpa_data_o     (rs1_data),
    .rpb_addr_i     (ctrl.rs2),
    .rpb_data_o     (rs2_data),
    .wpc_addr_i     (wb.rd),
    .wpc_data_i     (wb.data),
    .wpc_we_i       (wb.valid),
    .reg_alu_dest_i (ctrl.rd),
    .reg_alu_dest_o (wb_dest),
    .reg_alu_wb_i   (ctrl.valid),
    .reg_alu_wb_o   (wb_en)
  );

  // Same bundle also feeds the forwarding path
  jedro_1_alu u_alu (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .ctrl_i     (ctrl),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .fwd_i      (wb),
    .result_o   (alu_result)
  );

  // Writeback bundle from the buffer stage and the result register
  assign wb.valid = wb_en;
  assign wb.rd    = wb_dest;
  assign wb.data  = alu_result;

  assign wb_o = wb;

endmodule

// ==== verif/jedro_1_sva.sv ====
// Jedro-1 writeback assertions

module jedro_1_sva import jedro_1_pkg::*; (
  input logic clk_i,
  input logic rstn_i,
  input logic instr_valid_i,
  input wb_t  wb_o,
  input logic illegal_o
);

  // Outputs quiet right after reset
  reset_quiet: assert property (@(posedge clk_i)
    $rose(rstn_i) |-> !wb_o.valid && !illegal_o)
    else $error("Writeback or illegal pulse in the first cycle after reset");

  // A flagged instruction never retires
  wb_ill_excl: assert property (@(posedge clk_i) disable iff (!rstn_i)
    illegal_o |=> !wb_o.valid)
    else $error("Writeback one cycle after an illegal pulse");

  // Legal instruction retires two edges after acceptance
  wb_latency: assert property (@(posedge clk_i) disable iff (!rstn_i)
    instr_valid_i ##1 !illegal_o |-> ##1 wb_o.valid)
    else $error("Legal instruction without a writeback two edges later");

  // No writeback without an accepted instruction
  wb_source: assert property (@(posedge clk_i) disable iff (!rstn_i)
    wb_o.valid |-> $past(instr_valid_i, 2))
    else $error("Writeback with no instruction accepted two edges earlier");

endmodule

bind jedro_1_exec_top jedro_1_sva u_sva (
  .clk_i         (clk_i),
  .rstn_i        (rstn_i),
  .instr_valid_i (instr_valid_i),
  .wb_o          (wb_o),
  .illegal_o     (illegal_o)
);

// ==== verif/jedro_1_tb.sv ====
// Jedro-1 execute slice testbench

module jedro_1_tb import jedro_1_pkg::*; ();

  localparam int          NUM_INSTR      = 2000;
  localparam int          IDLE_CYCLES    = 10;
  localparam int          RESET_CYCLES   = 10;
  localparam int          TIMEOUT_CYCLES = 4 * NUM_INSTR + 100;
  localparam logic [31:0] LFSR_SEED      = 32'h3787aaba;
  // x^32 + x^22 + x^2 + x + 1, right-shifting Galois form
  localparam logic [31:0] LFSR_TAPS      = 32'h80200003;

  logic        clk_i;
  logic        rstn_i;
  logic        instr_valid_i;
  logic [31:0] instr_i;
  wb_t         wb_o;
  logic        illegal_o;

  // Random source
  logic [31:0] lfsr;
  // Reference register state, program order
  logic [31:0] model_regs [NUM_REGS];
  // Expected writebacks, oldest first
  wb_t         exp_wb_q [$];
  // Per-cycle expectations, bit 0 is the newest slot
  logic [1:0]  ill_sr;
  logic [2:0]  wb_sr;
  int          issued;
  int          cycle_cnt;

  jedro_1_exec_top dut (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .wb_o          (wb_o),
    .illegal_o     (illegal_o)
  );

  ////////////////////////////////////////////////////////////
  // Random bits
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ LFSR_TAPS;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit, MSB drawn first
  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // Mostly x0-x7 so dependences are frequent
  task automatic pick_reg(output logic [4:0] idx);
    logic [31:0] r;
    take_bits(2, r);
    if (r[1:0] == 2'b00) begin
      take_bits(5, r);
    end else begin
      take_bits(3, r);
    end
    idx = r[4:0];
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // RV32I integer result by funct3, alt selects SUB and SRA
  function automatic logic [31:0] rv32_op(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic [4:0]  sh;
    logic [31:0] fill;
    sh = b[4:0];
    // Sign bits shifted in by SRA
    fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
    case (f3)
      3'd0:    rv32_op = alt ? a - b : a + b;
      3'd1:    rv32_op = a << sh;
      // Signed compare by flipping both sign bits
      3'd2:    rv32_op = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
      3'd3:    rv32_op = (a < b) ? 32'd1 : 32'd0;
      3'd4:    rv32_op = a ^ b;
      3'd5:    rv32_op = alt ? ((a >> sh) | fill) : (a >> sh);
      3'd6:    rv32_op = a | b;
      default: rv32_op = a & b;
    endcase
  endfunction

  // Encodings outside the supported set
  task automatic build_illegal(input logic [4:0] rd, input logic [4:0] rs1,
                               input logic [4:0] rs2, output logic [31:0] word);
    logic [31:0] r;
    logic [31:0] op;
    logic [2:0]  f3;
    take_bits(2, r);
    take_bits(3, op);
    f3 = op[2:0];
    case (r[1:0])
      2'd0: begin
        // Unknown major opcode
        take_bits(7, op);
        if (op[6:0] == OPC_OP || op[6:0] == OPC_OP_IMM || op[6:0] == OPC_LUI) begin
          op[6:0] = 7'b1111111;
        end
        take_bits(25, r);
        word = {r[24:0], op[6:0]};
      end
      // M-extension funct7
      2'd1: word = {7'b0000001, rs2, rs1, f3, rd, OPC_OP};
      2'd2: begin
        // Alternate funct7 on a funct3 other than ADD/SUB and SRL/SRA
        if (f3 == 3'd0 || f3 == 3'd5) begin
          f3 = f3 + 3'd1;
        end
        word = {7'b0100000, rs2, rs1, f3, rd, OPC_OP};
      end
      default: begin
        // Shift immediate with bad upper bits
        take_bits(1, r);
        if (r[0]) begin
          word = {7'b0000001, rs2, rs1, 3'd5, rd, OPC_OP_IMM};
        end else begin
          word = {7'b0100000, rs2, rs1, 3'd1, rd, OPC_OP_IMM};
        end
      end
    endcase
  endtask

  // Draw one cycle of stimulus and predict its outcome
  task automatic issue_slot(input logic allow_valid);
    logic [31:0] r;
    logic [31:0] word;
    logic [31:0] b;
    logic [31:0] res;
    logic        valid;
    logic        bad;
    logic        alt;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    wb_t         entry;
    take_bits(2, r);
    valid = allow_valid && (r[1:0] != 2'b00);
    bad   = 1'b0;
    word  = '0;
    if (valid) begin
      issued++;
      take_bits(4, r);
      bad = (r[3:0] == 4'd0);
      pick_reg(rd);
      pick_reg(rs1);
      pick_reg(rs2);
      if (bad) begin
        build_illegal(rd, rs1, rs2, word);
      end else begin
        take_bits(3, r);
        take_bits(3, b);
        f3 = b[2:0];
        take_bits(1, b);
        alt = b[0] && (f3 == 3'd0 || f3 == 3'd5);
        if (r[2:0] <= 3'd2) begin
          // OP group
          res  = rv32_op(f3, alt, model_regs[rs1], model_regs[rs2]);
          word = {alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, OPC_OP};
        end else if (r[2:0] <= 3'd6) begin
          if (f3 == 3'd1 || f3 == 3'd5) begin
            // Shift amount in the rs2 field
            take_bits(5, b);
            word = {1'b0, alt, 5'b0, b[4:0], rs1, f3, rd, OPC_OP_IMM};
          end else begin
            alt = 1'b0;
            take_bits(12, r);
            b    = {{20{r[11]}}, r[11:0]};
            word = {r[11:0], rs1, f3, rd, OPC_OP_IMM};
          end
          res = rv32_op(f3, alt, model_regs[rs1], b);
        end else begin
          take_bits(20, r);
          res  = {r[19:0], 12'b0};
          word = {r[19:0], rd, OPC_LUI};
        end
        entry.valid = 1'b1;
        entry.rd    = rd;
        entry.data  = res;
        exp_wb_q.push_back(entry);
        // x0 writes show on wb_o but never land
        if (rd != 5'd0) begin
          model_regs[rd] = res;
        end
      end
    end
    instr_valid_i <= valid;
    instr_i       <= word;
    ill_sr = {ill_sr[0], bad};
    wb_sr  = {wb_sr[1:0], valid && !bad};
  endtask

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "Run stopped on the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("ERROR: time %0t signal %s expected 0x%08h actual 0x%08h",
             $time, name, expected, actual);
    abort_run();
  endtask

  // Illegal after one edge, writeback after two
  task automatic check_outputs();
    wb_t expected;
    assert (illegal_o == ill_sr[1]) else report_mismatch("illegal_o", ill_sr[1], illegal_o);
    assert (wb_o.valid == wb_sr[2]) else report_mismatch("wb_o.valid", wb_sr[2], wb_o.valid);
    if (wb_o.valid) begin
      assert (exp_wb_q.size() > 0) else begin
        $display("Writeback at time %0t with no instruction left to retire", $time);
        abort_run();
      end
      expected = exp_wb_q.pop_front();
      assert (wb_o.rd == expected.rd) else report_mismatch("wb_o.rd", expected.rd, wb_o.rd);
      assert (wb_o.data == expected.data)
        else report_mismatch("wb_o.data", expected.data, wb_o.data);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Clock, stimulus and timeout
  ////////////////////////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  initial begin
    rstn_i        = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    lfsr          = LFSR_SEED;
    ill_sr        = '0;
    wb_sr         = '0;
    issued        = 0;
    for (int i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    rstn_i <= 1'b1;
    // Drive on the rising edge, check on the falling edge
    while (issued < NUM_INSTR) begin
      @(posedge clk_i);
      issue_slot(1'b1);
      @(negedge clk_i);
      check_outputs();
    end
    // Drain the pipeline
    repeat (IDLE_CYCLES) begin
      @(posedge clk_i);
      issue_slot(1'b0);
      @(negedge clk_i);
      check_outputs();
    end
    assert (exp_wb_q.size() == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("%0d expected writebacks never appeared", exp_wb_q.size());
      abort_run();
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, the instruction stream never finished", cycle_cnt);
    abort_run();
  end

endmodule

// ==== sim.f ====
hw/jedro_1_pkg.sv
hw/jedro_1_decoder.sv
hw/jedro_1_regfile.sv
hw/jedro_1_alu.sv
hw/jedro_1_exec_top.sv
verif/jedro_1_sva.sv
verif/jedro_1_tb.sv
